// File: source/link_pkg.sv
// PHY lane layout for the die-to-die receive link
// Lane width, push and half strobe positions, tx credit and strobe bits
// Debug status word layout
package link_pkg;

  ////////////////////////////////////////////////////////////
  // PHY lane layout

  // One PHY lane, both directions
  localparam int LANE_WIDTH         = 24;

  // Rx lane control bits
  localparam int LANE_PUSH_BIT      = 23;
  // Marks the low half of a gen1 beat
  localparam int LANE_HALF_BIT      = 22;

  // Tx lane control bits
  localparam int LANE_CREDIT_BIT    = 23;
  localparam int LANE_STROBE_BIT    = 22;

  // Payload sits below the control bits
  localparam int LANE_PAYLOAD_WIDTH = 22;

  ////////////////////////////////////////////////////////////
  // Debug status layout

  localparam int DBG_WIDTH          = 16;
  // Sticky until reset
  localparam int DBG_OVERFLOW_BIT   = 15;
  localparam int DBG_ONLINE_BIT     = 14;
  // FIFO level in the low byte
  localparam int DBG_LEVEL_WIDTH    = 8;

endpackage

// File: source/stream_pkg.sv
// User stream beat widths
// Beat word as a packed union: stream fields or two lane halves
package stream_pkg;

  // User side widths
  localparam int DATA_WIDTH = 32;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // Beat word is two lane payloads wide
  localparam int BEAT_WIDTH = 44;
  localparam int HALF_WIDTH = BEAT_WIDTH / 2;

  // Unused top bits of the field view
  localparam int PAD_WIDTH  = BEAT_WIDTH - 1 - KEEP_WIDTH - DATA_WIDTH;

  // Field view of a beat
  typedef struct packed {
    logic [PAD_WIDTH-1:0]  pad;
    logic                  tlast;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic [DATA_WIDTH-1:0] tdata;
  } st_fields_t;

  // Lane view of a beat
  // hi comes from lane 1 in gen2, from the second word in gen1
  typedef struct packed {
    logic [HALF_WIDTH-1:0] hi;
    logic [HALF_WIDTH-1:0] lo;
  } st_halves_t;

  // Same 44 bits, two decodes
  typedef union packed {
    st_fields_t fields;
    st_halves_t halves;
  } st_beat_u;

endpackage

// File: source/link_sync.sv
// Link bring-up control
// Programmable online delays for rx and tx, persistent tx strobe
`timescale 1ns/10ps

module link_sync #(
  parameter int DELAY_WIDTH = 16
) (
  input  logic                   clk_wr,
  input  logic                   rst,
  input  logic                   rx_online,
  input  logic                   tx_online,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_y_value,
  output logic                   rx_online_delay,
  output logic                   tx_online_delay,
  output logic                   tx_strobe
);

  ////////////////////////////////////////////////////////////
  // Channel inputs, 0 is rx and 1 is tx

  logic [1:0]             online_in;
  logic [DELAY_WIDTH-1:0] delay_in [2];

  assign online_in   = {tx_online, rx_online};
  assign delay_in[0] = delay_x_value;
  assign delay_in[1] = delay_y_value;

  ////////////////////////////////////////////////////////////
  // One delay counter per channel

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic [DELAY_WIDTH-1:0] count;
    logic                   online_q;

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        count    <= '0;
        online_q <= 1'b0;
      end else if (!online_in[ch]) begin
        // Input dropped, restart on next rise
        count    <= '0;
        online_q <= 1'b0;
      end else if (count < delay_in[ch]) begin
        count    <= count + 1'b1;
      end else begin
        // Delay reached, level holds while input stays high
        online_q <= 1'b1;
      end
    end
  end

  assign rx_online_delay = g_chan[0].online_q;
  assign tx_online_delay = g_chan[1].online_q;

  // No user marker here, so the strobe simply
  // stays up for as long as tx is online
  assign tx_strobe       = g_chan[1].online_q;

endmodule

// File: source/phy_unpack.sv
// Rx PHY lane sampling
// Gen2 beat capture from both lanes, gen1 two-word assembly on lane 0
// Push strobe and beat word out to the receive FIFO
`timescale 1ns/10ps

module phy_unpack
  import link_pkg::*;
  import stream_pkg::*;
(
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  gen2_mode,
  input  logic [LANE_WIDTH-1:0] rx_phy0,
  input  logic [LANE_WIDTH-1:0] rx_phy1,
  output logic                  beat_push,
  output st_beat_u              beat
);

  ////////////////////////////////////////////////////////////
  // Lane fields

  logic                          lane0_push;
  logic                          lane0_half;
  logic [LANE_PAYLOAD_WIDTH-1:0] lane0_payload;
  logic [LANE_PAYLOAD_WIDTH-1:0] lane1_payload;

  assign lane0_push    = rx_phy0[LANE_PUSH_BIT];
  assign lane0_half    = rx_phy0[LANE_HALF_BIT];
  assign lane0_payload = rx_phy0[LANE_PAYLOAD_WIDTH-1:0];
  // Lane 1 carries payload only
  assign lane1_payload = rx_phy1[LANE_PAYLOAD_WIDTH-1:0];

  ////////////////////////////////////////////////////////////
  // Push control

  logic                          push_q;
  logic                          lo_pending;
  logic [LANE_PAYLOAD_WIDTH-1:0] lo_hold;
  st_beat_u                      beat_q;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      push_q     <= 1'b0;
      lo_pending <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (gen2_mode) begin
        // Whole beat every pushed cycle
        lo_pending <= 1'b0;
        push_q     <= lane0_push;
      end else if (lane0_push) begin
        if (lane0_half) begin
          // Low half, a newer one replaces an older one
          lo_pending <= 1'b1;
        end else if (lo_pending) begin
          push_q     <= 1'b1;
          lo_pending <= 1'b0;
        end
        // High word with no low half is dropped
      end
    end
  end

  // Beat payload, no reset needed
  always_ff @(posedge clk_wr) begin
    if (lane0_push) begin
      if (gen2_mode) begin
        beat_q.halves.lo <= lane0_payload;
        beat_q.halves.hi <= lane1_payload;
      end else if (lane0_half) begin
        lo_hold <= lane0_payload;
      end else begin
        beat_q.halves.lo <= lo_hold;
        beat_q.halves.hi <= lane0_payload;
      end
    end
  end

  assign beat_push = push_q;
  assign beat      = beat_q;

endmodule

// File: source/rx_fifo.sv
// Receive FIFO, DEPTH beats, single clock
// Online gating of pushes, sticky overflow flag
// One credit pulse per pop, debug status word
`timescale 1ns/10ps

module rx_fifo
  import link_pkg::*;
  import stream_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 rx_online,
  input  logic                 beat_push,
  input  st_beat_u             beat,
  input  logic                 fifo_pop,
  output logic                 fifo_valid,
  output st_beat_u             fifo_beat,
  output logic                 credit_pulse,
  output logic [DBG_WIDTH-1:0] debug_status
);

  localparam int AW = $clog2(DEPTH);

  ////////////////////////////////////////////////////////////
  // Storage and pointers

  st_beat_u        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  // One bit wider than the pointers to hold DEPTH
  logic [AW:0]     level;
  logic            full;
  logic            push_ok;
  logic            pop_ok;
  logic            overflow;
  logic            credit_q;

  assign full    = (level == (AW + 1)'(DEPTH));
  // Pushes count only once the link is up
  assign push_ok = beat_push && rx_online && !full;
  assign pop_ok  = fifo_pop && fifo_valid;

  always_ff @(posedge clk_wr) begin
    if (push_ok) begin
      mem[wr_ptr] <= beat;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
      credit_q <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Level tracks push minus pop
      if (push_ok && !pop_ok) begin
        level <= level + 1'b1;
      end else if (pop_ok && !push_ok) begin
        level <= level - 1'b1;
      end
      // Beat dropped when full, flag stays until reset
      if (beat_push && rx_online && full) begin
        overflow <= 1'b1;
      end
      // Credit back to the far end, one cycle per pop
      credit_q <= pop_ok;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs

  assign fifo_valid   = (level != '0);
  assign fifo_beat    = mem[rd_ptr];
  assign credit_pulse = credit_q;

  always_comb begin
    debug_status                        = '0;
    debug_status[DBG_OVERFLOW_BIT]      = overflow;
    debug_status[DBG_ONLINE_BIT]        = rx_online;
    debug_status[DBG_LEVEL_WIDTH-1:0]   = DBG_LEVEL_WIDTH'(level);
  end

endmodule

// File: source/st_user_map.sv
// User stream output stage
// One register with valid/ready, tdata bytes masked by tkeep
`timescale 1ns/10ps

module st_user_map
  import stream_pkg::*;
(
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  fifo_valid,
  input  st_beat_u              fifo_beat,
  output logic                  fifo_pop,
  output logic [DATA_WIDTH-1:0] user_tdata,
  output logic [KEEP_WIDTH-1:0] user_tkeep,
  output logic                  user_tlast,
  output logic                  user_tvalid,
  input  logic                  user_tready
);

  logic [DATA_WIDTH-1:0] masked_data;
  logic [DATA_WIDTH-1:0] tdata_q;
  logic [KEEP_WIDTH-1:0] tkeep_q;
  logic                  tlast_q;
  logic                  valid_q;

  // Zero every byte whose keep bit is clear
  always_comb begin
    masked_data = fifo_beat.fields.tdata;
    for (int b = 0; b < KEEP_WIDTH; b++) begin
      if (!fifo_beat.fields.tkeep[b]) begin
        masked_data[8*b +: 8] = '0;
      end
    end
  end

  // Refill when empty or the held beat is taken this cycle
  assign fifo_pop = fifo_valid && (!valid_q || user_tready);

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fifo_pop) begin
      valid_q <= 1'b1;
    end else if (user_tready) begin
      valid_q <= 1'b0;
    end
  end

  // Payload held while stalled
  always_ff @(posedge clk_wr) begin
    if (fifo_pop) begin
      tdata_q <= masked_data;
      tkeep_q <= fifo_beat.fields.tkeep;
      tlast_q <= fifo_beat.fields.tlast;
    end
  end

  assign user_tdata  = tdata_q;
  assign user_tkeep  = tkeep_q;
  assign user_tlast  = tlast_q;
  assign user_tvalid = valid_q;

endmodule

// File: source/st_rx_top.sv
// Receive side top level of the streaming link
// Link control, lane unpack, receive FIFO and user stream stage
// Tx lane built from credit and strobe bits
`timescale 1ns/10ps

module st_rx_top
  import link_pkg::*;
  import stream_pkg::*;
#(
  parameter int DEPTH       = 16,
  parameter int DELAY_WIDTH = 16
) (
  input  logic                   clk_wr,
  input  logic                   rst,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic                   gen2_mode,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_y_value,
  input  logic [LANE_WIDTH-1:0]  rx_phy0,
  input  logic [LANE_WIDTH-1:0]  rx_phy1,
  output logic [LANE_WIDTH-1:0]  tx_phy0,
  output logic [DATA_WIDTH-1:0]  user_tdata,
  output logic [KEEP_WIDTH-1:0]  user_tkeep,
  output logic                   user_tlast,
  output logic                   user_tvalid,
  input  logic                   user_tready,
  output logic [DBG_WIDTH-1:0]   rx_debug_status
);

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic     rx_online_delay;
  logic     tx_online_delay;
  logic     tx_strobe;
  logic     beat_push;
  st_beat_u beat;
  logic     fifo_valid;
  st_beat_u fifo_beat;
  logic     fifo_pop;
  logic     credit_pulse;

  link_sync #(.DELAY_WIDTH(DELAY_WIDTH)) u_link_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .rx_online       (rx_online),
    .tx_online       (tx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .rx_online_delay (rx_online_delay),
    .tx_online_delay (tx_online_delay),
    .tx_strobe       (tx_strobe)
  );

  phy_unpack u_phy_unpack (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .gen2_mode (gen2_mode),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .beat_push (beat_push),
    .beat      (beat)
  );

  rx_fifo #(.DEPTH(DEPTH)) u_rx_fifo (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .rx_online    (rx_online_delay),
    .beat_push    (beat_push),
    .beat         (beat),
    .fifo_pop     (fifo_pop),
    .fifo_valid   (fifo_valid),
    .fifo_beat    (fifo_beat),
    .credit_pulse (credit_pulse),
    .debug_status (rx_debug_status)
  );

  st_user_map u_st_user_map (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .fifo_valid  (fifo_valid),
    .fifo_beat   (fifo_beat),
    .fifo_pop    (fifo_pop),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready)
  );

  ////////////////////////////////////////////////////////////
  // Tx lane, payload unused on this side

  always_comb begin
    tx_phy0                  = '0;
    // Credits only go out once tx is up
    tx_phy0[LANE_CREDIT_BIT] = credit_pulse && tx_online_delay;
    tx_phy0[LANE_STROBE_BIT] = tx_strobe;
  end

endmodule

// File: bench/st_rx_assertions.sv
// Concurrent checks on the receive FIFO and the user stream stage
// Bound into rx_fifo and st_user_map, unused ports tied off
// Failure count per instance
`timescale 1ns/10ps

module st_rx_assertions
  import stream_pkg::*;
#(
  parameter int DEPTH = 16
) (
  input logic                  clk_wr,
  input logic                  rst,
  input logic [$clog2(DEPTH):0] level,
  input logic                  fifo_pop,
  input logic                  fifo_valid,
  input logic                  credit_pulse,
  input logic                  tvalid,
  input logic                  tready,
  input logic [DATA_WIDTH-1:0] tdata,
  input logic [KEEP_WIDTH-1:0] tkeep,
  input logic                  tlast
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] LEVEL_MAX = (AW + 1)'(DEPTH);

  // Assertion failures in this instance
  int fail_count = 0;

  // FIFO never holds more than DEPTH
  a_level_bound: assert property (@(posedge clk_wr) disable iff (rst)
    level <= LEVEL_MAX)
    else begin
      $error("FIFO level above depth");
      fail_count++;
    end

  // Stalled beat holds its payload
  a_stream_hold: assert property (@(posedge clk_wr) disable iff (rst)
    (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast)))
    else begin
      $error("Stream beat changed while stalled");
      fail_count++;
    end

  // Credit only on the cycle after a real pop
  a_credit_pop: assert property (@(posedge clk_wr) disable iff (rst)
    credit_pulse |-> $past(fifo_pop && fifo_valid))
    else begin
      $error("Credit pulse without a FIFO pop");
      fail_count++;
    end

endmodule

bind rx_fifo st_rx_assertions #(.DEPTH(DEPTH)) u_fifo_assertions (
  .clk_wr       (clk_wr),
  .rst          (rst),
  .level        (level),
  .fifo_pop     (fifo_pop),
  .fifo_valid   (fifo_valid),
  .credit_pulse (credit_pulse),
  .tvalid       (1'b0),
  .tready       (1'b0),
  .tdata        ('0),
  .tkeep        ('0),
  .tlast        (1'b0)
);

bind st_user_map st_rx_assertions u_stream_assertions (
  .clk_wr       (clk_wr),
  .rst          (rst),
  .level        ('0),
  .fifo_pop     (fifo_pop),
  .fifo_valid   (fifo_valid),
  .credit_pulse (1'b0),
  .tvalid       (user_tvalid),
  .tready       (user_tready),
  .tdata        (user_tdata),
  .tkeep        (user_tkeep),
  .tlast        (user_tlast)
);

// File: bench/st_rx_tb.sv
// Testbench for the stream receive top level
// Clock, reset, test table, lane driver, stream checker
// Watchdog and run summary
`timescale 1ns/10ps

module st_rx_tb
  import link_pkg::*;
  import stream_pkg::*;
();

  localparam int DEPTH      = 16;
  localparam int DLY_W      = 16;
  localparam int DELAY_X    = 12;
  localparam int DELAY_Y    = 20;
  localparam int NUM_TESTS  = 6;
  localparam int CLK_PERIOD = 40;

  logic                  clk_wr;
  logic                  rst;
  logic                  tx_online;
  logic                  rx_online;
  logic                  gen2_mode;
  logic [DLY_W-1:0]      delay_x_value;
  logic [DLY_W-1:0]      delay_y_value;
  logic [LANE_WIDTH-1:0] rx_phy0;
  logic [LANE_WIDTH-1:0] rx_phy1;
  logic [LANE_WIDTH-1:0] tx_phy0;
  logic [DATA_WIDTH-1:0] user_tdata;
  logic [KEEP_WIDTH-1:0] user_tkeep;
  logic                  user_tlast;
  logic                  user_tvalid;
  logic                  user_tready;
  logic [DBG_WIDTH-1:0]  rx_debug_status;

  st_rx_top #(.DEPTH(DEPTH), .DELAY_WIDTH(DLY_W)) UUT (.*);

  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////
  // Test table and run state

  // Ready rule: 0 always high, 1 random, 2 low until all beats sent
  string t_name     [NUM_TESTS];
  bit    t_gen2     [NUM_TESTS];
  int    t_beats    [NUM_TESTS];
  int    t_ready    [NUM_TESTS];
  bit    t_online   [NUM_TESTS];
  bit    t_overflow [NUM_TESTS];

  int          seed;
  int          ready_mode;
  int          cyc;
  int          errors;
  int          passed;
  int          got_count;
  int          credit_count;
  bit          strobe_up;
  bit          table_ready;
  string       cur_name;
  // Expected {tlast, tkeep, masked tdata} in arrival order
  logic [36:0] exp_q [$];

  task automatic set_row(input int i, input string name, input bit gen2, input int beats,
                         input int ready, input bit online, input bit ovf);
    t_name[i]     = name;
    t_gen2[i]     = gen2;
    t_beats[i]    = beats;
    t_ready[i]    = ready;
    t_online[i]   = online;
    t_overflow[i] = ovf;
  endtask

  task automatic load_table();
    set_row(0, "gen2_delivery",      1'b1, 24,        0, 1'b1, 1'b0);
    set_row(1, "gen1_assembly",      1'b0, 20,        0, 1'b1, 1'b0);
    set_row(2, "gen2_back_pressure", 1'b1, 16,        1, 1'b1, 1'b0);
    set_row(3, "gen1_back_pressure", 1'b0, 16,        1, 1'b1, 1'b0);
    set_row(4, "overflow",           1'b1, DEPTH + 3, 2, 1'b1, 1'b1);
    set_row(5, "online_gating",      1'b1, 8,         0, 1'b0, 1'b0);
  endtask

  // Failures counted by the bound checkers
  function automatic int assertion_failures();
    return UUT.u_rx_fifo.u_fifo_assertions.fail_count
         + UUT.u_st_user_map.u_stream_assertions.fail_count;
  endfunction

  ////////////////////////////////////////////////////////////
  // Beat model

  // Bytes with a clear keep bit read as zero
  function automatic logic [31:0] mask_bytes(input logic [31:0] data, input logic [3:0] keep);
    logic [31:0] m;
    m = data;
    for (int b = 0; b < 4; b++) begin
      if (!keep[b]) m[8*b +: 8] = 8'h00;
    end
    return m;
  endfunction

  task automatic make_beat(output logic [43:0] word, output logic [36:0] exp_w);
    logic [31:0] data;
    logic [31:0] r;
    data  = $random(seed);
    r     = $random(seed);
    // Pad, tlast, tkeep, tdata from the top down
    word  = {7'd0, r[4], r[3:0], data};
    exp_w = {r[4], r[3:0], mask_bytes(data, r[3:0])};
  endtask

  ////////////////////////////////////////////////////////////
  // Driver

  // One cycle, inputs change 2 ns after the edge
  task automatic step();
    logic [31:0] r;
    @(posedge clk_wr);
    #2;
    cyc++;
    r = $random(seed);
    case (ready_mode)
      0:       user_tready = 1'b1;
      1:       user_tready = (r[1:0] != 2'b00);
      default: user_tready = 1'b0;
    endcase
  endtask

  task automatic send_beat(input logic [43:0] word);
    if (gen2_mode) begin
      rx_phy0 = {1'b1, 1'b0, word[21:0]};
      rx_phy1 = {2'b00, word[43:22]};
      step();
    end else begin
      // Low half first, marked by the half bit
      rx_phy0 = {1'b1, 1'b1, word[21:0]};
      step();
      rx_phy0 = {1'b1, 1'b0, word[43:22]};
      step();
    end
    rx_phy0 = '0;
    rx_phy1 = '0;
  endtask

  task automatic apply_reset();
    rst         = 1'b1;
    rx_online   = 1'b0;
    tx_online   = 1'b0;
    rx_phy0     = '0;
    rx_phy1     = '0;
    ready_mode  = 2;
    strobe_up   = 1'b0;
    exp_q.delete();
    repeat (8) step();
    got_count    = 0;
    credit_count = 0;
    rst          = 1'b0;
  endtask

  // Raise both online inputs, measure the delayed rise of each
  task automatic bring_up(input bit early);
    int          c0;
    int          rx_cyc;
    int          tx_cyc;
    logic [43:0] word;
    logic [36:0] dropped;
    rx_online = 1'b1;
    tx_online = 1'b1;
    c0        = cyc;
    rx_cyc    = -1;
    tx_cyc    = -1;
    if (early) begin
      // Pushed while the rx side is still held back
      for (int k = 0; k < 3; k++) begin
        make_beat(word, dropped);
        send_beat(word);
      end
    end
    while ((rx_cyc < 0 || tx_cyc < 0) && (cyc - c0 < DELAY_X + DELAY_Y + 8)) begin
      step();
      // Counted from the edge that first samples the input
      if (rx_cyc < 0 && rx_debug_status[DBG_ONLINE_BIT]) rx_cyc = cyc - c0 - 1;
      if (tx_cyc < 0 && tx_phy0[LANE_STROBE_BIT]) tx_cyc = cyc - c0 - 1;
    end
    if (rx_cyc != DELAY_X) begin
      $display("Error %s rx online delay expected %0d actual %0d", cur_name, DELAY_X, rx_cyc);
      errors++;
    end
    if (tx_cyc != DELAY_Y) begin
      $display("Error %s tx strobe delay expected %0d actual %0d", cur_name, DELAY_Y, tx_cyc);
      errors++;
    end
    if (rx_debug_status[DBG_LEVEL_WIDTH-1:0] != 8'd0) begin
      $display("Error %s level after bring-up expected 0 actual %0d",
               cur_name, rx_debug_status[DBG_LEVEL_WIDTH-1:0]);
      errors++;
    end
    strobe_up = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Stream checker and credit counter, sampled mid-cycle

  always @(negedge clk_wr) begin
    logic [36:0] exp_w;
    if (!rst) begin
      if (user_tvalid && user_tready) begin
        if (exp_q.size() == 0) begin
          $display("%s: a beat came out that was never expected", cur_name);
          errors++;
        end else begin
          exp_w = exp_q.pop_front();
          got_count++;
          if (user_tdata !== exp_w[31:0]) begin
            $display("Error %s beat %0d tdata expected %h actual %h",
                     cur_name, got_count, exp_w[31:0], user_tdata);
            errors++;
          end
          if (user_tkeep !== exp_w[35:32] || user_tlast !== exp_w[36]) begin
            $display("Error %s beat %0d tlast/tkeep expected %b/%h actual %b/%h",
                     cur_name, got_count, exp_w[36], exp_w[35:32], user_tlast, user_tkeep);
            errors++;
          end
        end
      end
      if (tx_phy0[LANE_CREDIT_BIT]) credit_count++;
      // Strobe is persistent once up
      if (strobe_up && !tx_phy0[LANE_STROBE_BIT]) begin
        $display("%s: tx strobe dropped while tx stayed online", cur_name);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // One table row

  task automatic run_test(input int i);
    int          start_errors;
    int          start_asserts;
    int          accepted;
    logic [43:0] word;
    logic [36:0] exp_w;
    start_errors  = errors;
    start_asserts = assertion_failures();
    cur_name      = t_name[i];
    gen2_mode     = t_gen2[i];
    apply_reset();
    bring_up(!t_online[i]);
    ready_mode = t_ready[i];
    // Full stall keeps DEPTH in the FIFO plus one in the output register
    accepted = t_overflow[i] ? DEPTH + 1 : t_beats[i];
    for (int b = 0; b < t_beats[i]; b++) begin
      make_beat(word, exp_w);
      if (b < accepted) exp_q.push_back(exp_w);
      send_beat(word);
    end
    if (t_ready[i] == 2) begin
      repeat (4) step();
      if (!rx_debug_status[DBG_OVERFLOW_BIT]) begin
        $display("%s: overflow flag did not rise on a full FIFO", cur_name);
        errors++;
      end
      if (rx_debug_status[DBG_LEVEL_WIDTH-1:0] != 8'(DEPTH)) begin
        $display("Error %s full level expected %0d actual %0d",
                 cur_name, DEPTH, rx_debug_status[DBG_LEVEL_WIDTH-1:0]);
        errors++;
      end
      ready_mode = 0;
    end
    while (exp_q.size() != 0) step();
    repeat (4) step();
    if (got_count != accepted || credit_count != accepted) begin
      $display("Error %s beats/credits expected %0d/%0d actual %0d/%0d",
               cur_name, accepted, accepted, got_count, credit_count);
      errors++;
    end
    if (user_tvalid !== 1'b0) begin
      $display("%s: tvalid still high after the last expected beat", cur_name);
      errors++;
    end
    if (rx_debug_status[DBG_OVERFLOW_BIT] != t_overflow[i]) begin
      $display("Error %s overflow flag expected %0d actual %0d",
               cur_name, t_overflow[i], rx_debug_status[DBG_OVERFLOW_BIT]);
      errors++;
    end
    if (assertion_failures() != start_asserts) begin
      $display("%s: %0d concurrent assertion failures during the test",
               cur_name, assertion_failures() - start_asserts);
      errors += assertion_failures() - start_asserts;
    end
    if (errors == start_errors) begin
      passed++;
      $display("Test %s: ok, %0d beats checked", cur_name, got_count);
    end else begin
      $display("Test %s: %0d errors", cur_name, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    clk_wr        = 1'b0;
    rst           = 1'b1;
    rx_online     = 1'b0;
    tx_online     = 1'b0;
    gen2_mode     = 1'b1;
    delay_x_value = 16'(DELAY_X);
    delay_y_value = 16'(DELAY_Y);
    rx_phy0       = '0;
    rx_phy1       = '0;
    user_tready   = 1'b0;
    seed          = 32'he027;
    ready_mode    = 2;
    cyc           = 0;
    errors        = 0;
    passed        = 0;
    got_count     = 0;
    credit_count  = 0;
    strobe_up     = 1'b0;
    load_table();
    table_ready   = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, passed, NUM_TESTS - passed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget of 8 cycles per beat plus reset and bring-up per test
  initial begin
    int total;
    wait (table_ready);
    total = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      total += t_beats[i] * 8 + 8 + DELAY_X + DELAY_Y + 20;
    end
    #(total * CLK_PERIOD);
    $display("Watchdog: the run did not finish within %0d cycles", total);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: sim.f
source/link_pkg.sv
source/stream_pkg.sv
source/link_sync.sv
source/phy_unpack.sv
source/rx_fifo.sv
source/st_user_map.sv
source/st_rx_top.sv
bench/st_rx_assertions.sv
bench/st_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream receive testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module st_rx_tb \
    -f sim.f -o st_rx_sim > build.log 2>&1 \
  && ./obj_dir/st_rx_sim > sim.log 2>&1 \
  && ! grep -q "Regression failed" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
